// File: common/sc_pkg.sv
`default_nettype none

package sc_pkg;

   // sequencer states
   typedef enum logic [1:0] {
      IDLE  = 2'd0,
      RUN   = 2'd1,
      DRAIN = 2'd2
   } seq_state_t;

   // default operand width in bits
   localparam int DEF_WIDTH = 4;

   // default number of multiply lanes
   localparam int DEF_LANES = 4;

   // a run spans 2**(2*WIDTH) cycles.
   // The low phase half drives the a stream and the high half drives the b stream,
   // so every (lo, hi) pair appears exactly once per run.

endpackage

`default_nettype wire

// File: hw/sc_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module sc_sequencer #(
   parameter int WIDTH = sc_pkg::DEF_WIDTH
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               start,
   output logic               busy,
   output logic               load,
   output logic               run,
   output logic [2*WIDTH-1:0] phase,
   output logic               last
);

   import sc_pkg::*;

   localparam int PH_W = 2 * WIDTH;

   seq_state_t      state;
   logic            load_q;    // operand latch strobe, first RUN cycle
   logic [PH_W-1:0] phase_q;
   logic            phase_end;

   assign phase_end = &phase_q;

   // load cycle first, then 2**PH_W counting cycles, then one drain cycle
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state   <= IDLE;
         load_q  <= 1'b0;
         phase_q <= '0;
      end else begin
         load_q <= 1'b0;
         case (state)
            IDLE: begin
               if (start) begin   // start ignored outside IDLE
                  state   <= RUN;
                  load_q  <= 1'b1;
                  phase_q <= '0;
               end
            end
            RUN: begin
               if (!load_q) begin
                  phase_q <= phase_q + 1'b1;   // wraps back to zero at the end
                  if (phase_end) begin
                     state <= DRAIN;
                  end
               end
            end
            DRAIN: begin
               state <= IDLE;   // lanes hold counts, accumulator sums
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   assign busy  = (state != IDLE);
   assign load  = load_q;

   // lanes count only once operands are latched
   assign run   = (state == RUN) && !load_q;
   assign phase = phase_q;
   assign last  = run && phase_end;

endmodule

`default_nettype wire

// File: sc_lane/sc_lane.sv
`timescale 1ns/10ps
`default_nettype none

module sc_lane #(
   parameter int WIDTH = sc_pkg::DEF_WIDTH
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               load,
   input  logic               run,
   input  logic [WIDTH-1:0]   a,
   input  logic [WIDTH-1:0]   b,
   input  logic [2*WIDTH-1:0] phase,
   output logic [2*WIDTH-1:0] count
);

   localparam int CNT_W = 2 * WIDTH;

   logic [WIDTH-1:0] a_q;
   logic [WIDTH-1:0] b_q;
   logic [WIDTH-1:0] phase_lo;
   logic [WIDTH-1:0] phase_hi;
   logic             a_bit;
   logic             b_bit;
   logic             prod_bit;

   // operand latch
   always_ff @(posedge clk) begin
      if (load) begin
         a_q <= a;
         b_q <= b;
      end
   end

   assign phase_lo = phase[WIDTH-1:0];
   assign phase_hi = phase[CNT_W-1:WIDTH];

   // binary to stochastic conversion.
   // The low half sweeps fastest, so the a stream holds a ones in every group of
   // 2**WIDTH cycles. The high half steps once per group, so the b stream stays
   // high for b whole groups.
   assign a_bit = (a_q > phase_lo);
   assign b_bit = (b_q > phase_hi);

   // unipolar multiply
   assign prod_bit = a_bit & b_bit;

   // stochastic to binary, counts ones over one full period.
   // The largest product (2**WIDTH-1)**2 fits in CNT_W bits, so no overflow.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         count <= '0;
      end else if (load) begin
         count <= '0;   // fresh run
      end else if (run && prod_bit) begin
         count <= count + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: hw/sc_accum.sv
`timescale 1ns/10ps
`default_nettype none

module sc_accum #(
   parameter int WIDTH = sc_pkg::DEF_WIDTH,
   parameter int LANES = sc_pkg::DEF_LANES
) (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                last,
   input  logic [LANES*2*WIDTH-1:0]            counts,
   output logic [2*WIDTH+$clog2(LANES)-1:0]    result,
   output logic                                done
);

   localparam int CNT_W = 2 * WIDTH;
   localparam int RES_W = 2 * WIDTH + $clog2(LANES);

   logic             pending;   // last seen, lane counts settle this cycle
   logic [RES_W-1:0] sum;

   // adder over all lane counts
   always_comb begin
      sum = '0;
      for (int i = 0; i < LANES; i++) begin
         sum = sum + RES_W'(counts[i*CNT_W +: CNT_W]);
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pending <= 1'b0;
         done    <= 1'b0;
         result  <= '0;
      end else begin
         pending <= last;
         done    <= pending;   // single cycle pulse
         if (pending) begin
            result <= sum;   // held until the next run drains
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/sc_dot_top.sv
`timescale 1ns/10ps
`default_nettype none

module sc_dot_top #(
   parameter int WIDTH = sc_pkg::DEF_WIDTH,
   parameter int LANES = sc_pkg::DEF_LANES
) (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             start,
   input  logic [LANES*WIDTH-1:0]           a_ops,
   input  logic [LANES*WIDTH-1:0]           b_ops,
   output logic                             busy,
   output logic                             done,
   output logic [2*WIDTH+$clog2(LANES)-1:0] result
);

   localparam int CNT_W = 2 * WIDTH;

   logic                   load;
   logic                   run;
   logic                   last;
   logic [CNT_W-1:0]       phase;
   logic [LANES*CNT_W-1:0] counts;   // lane counts, lane 0 in the low bits

   // shared phase for every lane
   sc_sequencer #(
      .WIDTH (WIDTH)
   ) sc_sequencer_i (
      .clk   (clk),
      .rst   (rst),
      .start (start),
      .busy  (busy),
      .load  (load),
      .run   (run),
      .phase (phase),
      .last  (last)
   );

   for (genvar i = 0; i < LANES; i++) begin : g_lane
      sc_lane #(
         .WIDTH (WIDTH)
      ) sc_lane_i (
         .clk   (clk),
         .rst   (rst),
         .load  (load),
         .run   (run),
         .a     (a_ops[i*WIDTH +: WIDTH]),
         .b     (b_ops[i*WIDTH +: WIDTH]),
         .phase (phase),
         .count (counts[i*CNT_W +: CNT_W])
      );
   end

   sc_accum #(
      .WIDTH (WIDTH),
      .LANES (LANES)
   ) sc_accum_i (
      .clk    (clk),
      .rst    (rst),
      .last   (last),
      .counts (counts),
      .result (result),
      .done   (done)
   );

endmodule

`default_nettype wire

// File: dv/sc_dot_tb.sv
`timescale 1ns/10ps
`default_nettype none

module sc_dot_tb;

   localparam int WIDTH     = 4;
   localparam int LANES     = 4;
   localparam int OP_W      = LANES * WIDTH;
   localparam int RES_W     = 2 * WIDTH + $clog2(LANES);
   localparam int FIELDS    = 2 * LANES + 1;   // a values, b values, expected
   localparam int MAX_CASES = 64;
   localparam int TIMEOUT   = 400;
   localparam int N_RANDOM  = 20;
   localparam logic [15:0] END_MARK = 16'hffff;

   logic             clk;
   logic             rst;
   logic             start;
   logic [OP_W-1:0]  a_ops;
   logic [OP_W-1:0]  b_ops;
   logic             busy;
   logic             done;
   logic [RES_W-1:0] result;

   logic [15:0] case_mem [0:MAX_CASES*FIELDS-1];
   logic [15:0] lfsr;
   int          errors;
   int          tests_run;
   int          tests_failed;
   logic        test_ok;

   sc_dot_top #(
      .WIDTH (WIDTH),
      .LANES (LANES)
   ) sc_dot_top_i (
      .clk    (clk),
      .rst    (rst),
      .start  (start),
      .a_ops  (a_ops),
      .b_ops  (b_ops),
      .busy   (busy),
      .done   (done),
      .result (result)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // 16 bit Fibonacci LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   // expected dot product, straight from the operand slices
   function automatic logic [RES_W-1:0] dot_ref(input logic [OP_W-1:0] a_in,
                                                input logic [OP_W-1:0] b_in);
      logic [RES_W-1:0] acc;
      acc = '0;
      for (int l = 0; l < LANES; l++) begin
         acc = acc + RES_W'(a_in[l*WIDTH +: WIDTH]) * RES_W'(b_in[l*WIDTH +: WIDTH]);
      end
      return acc;
   endfunction

   task automatic draw_operand(output logic [WIDTH-1:0] v);
      v = '0;
      for (int i = 0; i < WIDTH; i++) begin
         lfsr = lfsr_step(lfsr);   // one step per bit
         v = {v[WIDTH-2:0], lfsr[0]};
      end
   endtask

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic note_error();
      errors++;
      test_ok = 1'b0;
   endtask

   task automatic report_failure(input string msg);
      $display("ERROR at %0d ns: %s", $time, msg);
      note_error();
   endtask

   task automatic check_result(input logic [RES_W-1:0] got, input logic [RES_W-1:0] exp,
                               input string what);
      if (got !== exp) begin
         $display("MISMATCH at %0d ns: %s, got %0d, expected %0d", $time, what, got, exp);
         note_error();
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("MISMATCH at %0d ns: %s, got %b, expected %b", $time, what, got, exp);
         note_error();
      end
   endtask

   task automatic begin_test();
      test_ok = 1'b1;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (!test_ok) begin
         tests_failed++;
      end
      $display("test %-20s %s", name, test_ok ? "ok" : "FAILED");
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while (busy && n < TIMEOUT) begin
         step();
         n++;
      end
      if (busy) begin
         report_failure("DUT stayed busy, could not start a new run");
      end
   endtask

   task automatic start_run(input logic [OP_W-1:0] a_in, input logic [OP_W-1:0] b_in);
      wait_idle();
      a_ops = a_in;   // held through the lane load edge
      b_ops = b_in;
      start = 1'b1;
      step();
      start = 1'b0;
      check_flag(busy, 1'b1, "busy after accepted start");
   endtask

   task automatic finish_run(input logic [RES_W-1:0] exp_res, input string what);
      int   n;
      logic busy_gap;
      n = 0;
      busy_gap = 1'b0;
      while (!done && n < TIMEOUT) begin
         if (!busy) begin
            busy_gap = 1'b1;
         end
         step();
         n++;
      end
      if (!done) begin
         report_failure($sformatf("no done pulse within %0d cycles (%s)", TIMEOUT, what));
      end else begin
         check_flag(busy_gap, 1'b0, {what, ": busy dropped before done"});
         check_result(result, exp_res, what);
         step();
         check_flag(done, 1'b0, {what, ": done longer than one cycle"});
         check_flag(busy, 1'b0, {what, ": busy after done"});
         check_result(result, exp_res, {what, ": result after done"});
      end
   endtask

   initial begin
      int               n_cases;
      int               base;
      string            name;
      logic [OP_W-1:0]  a_in;
      logic [OP_W-1:0]  b_in;
      logic [OP_W-1:0]  a_first;
      logic [OP_W-1:0]  b_first;
      logic [RES_W-1:0] exp_res;
      logic [WIDTH-1:0] v;

      rst          = 1'b1;
      start        = 1'b0;
      a_ops        = '0;
      b_ops        = '0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      test_ok      = 1'b1;
      lfsr         = 16'd20;

      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;

      // reset values
      begin_test();
      check_flag(busy, 1'b0, "busy after reset");
      check_flag(done, 1'b0, "done after reset");
      check_result(result, '0, "result after reset");
      end_test("reset");

      // file cases, list ends at the marker word
      $readmemh("dv/sc_dot_cases.txt", case_mem);
      n_cases = 0;
      while (n_cases < MAX_CASES && case_mem[n_cases*FIELDS] !== END_MARK) begin
         n_cases++;
      end
      begin_test();
      if (n_cases == 0 || n_cases == MAX_CASES) begin
         report_failure("case file is empty or has no end marker");
      end
      end_test("case file");

      for (int c = 0; c < n_cases && n_cases < MAX_CASES; c++) begin
         begin_test();
         base = c * FIELDS;
         for (int l = 0; l < LANES; l++) begin
            a_in[l*WIDTH +: WIDTH] = case_mem[base + l][WIDTH-1:0];
            b_in[l*WIDTH +: WIDTH] = case_mem[base + LANES + l][WIDTH-1:0];
         end
         exp_res = dot_ref(a_in, b_in);
         if (case_mem[base + 2*LANES] !== 16'(exp_res)) begin
            report_failure($sformatf("case %0d in file expects %0d, sum of products is %0d",
                                     c, case_mem[base + 2*LANES], exp_res));
         end
         name = $sformatf("file case %0d", c);
         start_run(a_in, b_in);
         finish_run(exp_res, name);
         end_test(name);
      end

      for (int r = 0; r < N_RANDOM; r++) begin
         begin_test();
         for (int l = 0; l < LANES; l++) begin
            draw_operand(v);
            a_in[l*WIDTH +: WIDTH] = v;
            draw_operand(v);
            b_in[l*WIDTH +: WIDTH] = v;
         end
         name = $sformatf("random case %0d", r);
         start_run(a_in, b_in);
         finish_run(dot_ref(a_in, b_in), name);
         end_test(name);
      end

      // second start during a run carries other operands
      begin_test();
      a_first = {4'h3, 4'h9, 4'hc, 4'h6};
      b_first = {4'ha, 4'h2, 4'h7, 4'hf};
      start_run(a_first, b_first);
      for (int i = 0; i < 12; i++) begin
         step();
         check_flag(busy, 1'b1, "busy during run");
      end
      a_ops = '1;
      b_ops = '1;
      start = 1'b1;
      step();
      start = 1'b0;
      check_flag(busy, 1'b1, "busy after ignored start");
      finish_run(dot_ref(a_first, b_first), "start while busy");
      end_test("start while busy");

      // result must survive operand changes while idle
      begin_test();
      exp_res = dot_ref(a_first, b_first);
      for (int l = 0; l < LANES; l++) begin
         draw_operand(v);
         a_ops[l*WIDTH +: WIDTH] = v;
         draw_operand(v);
         b_ops[l*WIDTH +: WIDTH] = v;
      end
      for (int i = 0; i < 30; i++) begin
         step();
         check_result(result, exp_res, "result held while idle");
      end
      check_flag(busy, 1'b0, "busy while idle");
      check_flag(done, 1'b0, "done while idle");
      end_test("result hold");

      $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: dv/sc_dot_cases.txt
// columns: a0 a1 a2 a3 b0 b1 b2 b3 expected, all hex, lane 0 first
// expected is the sum of a*b over the four lanes
// a line holding only ffff ends the list
0 0 0 0 0 0 0 0 000
f f f f f f f f 384
5 0 0 0 7 0 0 0 023
0 9 0 0 0 3 0 0 01b
0 0 c 0 0 0 d 0 09c
0 0 0 f 0 0 0 f 0e1
1 1 1 1 1 1 1 1 004
f 0 f 0 0 f 0 f 000
1 2 3 4 5 6 7 8 046
8 7 6 5 4 3 2 1 046
f f f f 1 1 1 1 03c
2 2 2 2 f f f f 078
a b c d e f 1 2 157
3 0 7 0 9 0 b 0 068
0 4 0 8 0 6 0 c 078
e d c b 2 3 4 5 0aa
7 7 7 7 7 7 7 7 0c4
8 8 8 8 8 8 8 8 100
f 1 f 1 1 f 1 f 03c
6 9 4 2 b 5 3 e 097
0 0 0 1 0 0 0 1 001
f e d c f e d c 2de
9 a 3 5 4 c 8 6 0d2
4 0 0 0 0 0 0 0 000
0 0 0 0 f f f f 000
c 3 5 a 6 f 2 7 0c5
2 4 8 f 8 4 2 1 03f
b 0 e 1 d 0 9 f 11c
1 3 5 7 2 4 6 8 064
d 6 0 f a 5 e 9 127
5 5 5 5 3 3 3 3 03c
0 f 0 0 0 f 0 0 0e1
7 e 1 8 9 2 f 4 08a
a a a a b b b b 1b8
f 0 0 0 f 0 0 0 0e1
3 6 9 c 4 8 c 0 0a8
ffff

// File: verilog.f
common/sc_pkg.sv
hw/sc_sequencer.sv
sc_lane/sc_lane.sv
hw/sc_accum.sv
hw/sc_dot_top.sv
dv/sc_dot_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
TOP       ?= sc_dot_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# build, run, and pass only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
